/* design/dcache_pkg.sv */
package dcache_pkg;

	// cache geometry
	localparam int WORD_W        = 32;
	localparam int SETS          = 8;
	// associativity
	localparam int WAYS          = 2;
	localparam int WORDS_PER_BLK = 2;

	// address layout tag | index | word offset | byte offset
	localparam int IDX_W     = $clog2(SETS);
	localparam int BLKOFF_W  = $clog2(WORDS_PER_BLK);
	localparam int BYTEOFF_W = 2;
	localparam int WAY_W     = $clog2(WAYS);
	localparam int TAG_W     = WORD_W - IDX_W - BLKOFF_W - BYTEOFF_W;

	// bit positions of the fields in a byte address
	localparam int IDX_LSB = BYTEOFF_W + BLKOFF_W;
	localparam int TAG_LSB = IDX_LSB + IDX_W;

	// flush walk covers sets x ways x words
	localparam int FLUSH_CNT_W = IDX_W + WAY_W + BLKOFF_W;

	// data word or byte address
	typedef logic [WORD_W-1:0] word_t;

	typedef logic [TAG_W-1:0] tag_t;

	// set index
	typedef logic [IDX_W-1:0] idx_t;

	// way select
	typedef logic [WAY_W-1:0] way_t;

	// word within a block
	typedef logic [BLKOFF_W-1:0] blkoff_t;

endpackage

/* design/dcache_tag_array.sv */
`timescale 1ns/10ps

module dcache_tag_array (
	input  logic               CLK,
	input  logic               nRST,
	input  dcache_pkg::idx_t   idx,
	input  dcache_pkg::tag_t   tag,
	input  dcache_pkg::way_t   way_sel,
	output logic               hit,
	output dcache_pkg::way_t   hit_way,
	output dcache_pkg::way_t   lru_way,
	output logic               sel_valid,
	output logic               sel_dirty,
	output dcache_pkg::tag_t   sel_tag,
	input  logic               tag_we,
	input  logic               new_valid,
	input  logic               new_dirty,
	input  dcache_pkg::tag_t   new_tag,
	input  logic               touch
);

	// per set state with one bit per way
	logic [dcache_pkg::WAYS-1:0] valid_q [dcache_pkg::SETS];
	logic [dcache_pkg::WAYS-1:0] dirty_q [dcache_pkg::SETS];
	dcache_pkg::tag_t            tag_q   [dcache_pkg::SETS][dcache_pkg::WAYS];
	// lru bit names the way to evict next
	dcache_pkg::way_t            lru_q   [dcache_pkg::SETS];

	logic [dcache_pkg::WAYS-1:0] match;

	// compare against both ways of the set
	assign match[0] = valid_q[idx][0] && (tag_q[idx][0] == tag);
	assign match[1] = valid_q[idx][1] && (tag_q[idx][1] == tag);

	assign hit     = |match;
	// way 0 when nothing matches
	assign hit_way = dcache_pkg::way_t'(match[1]);
	assign lru_way = lru_q[idx];

	// fields of the selected way
	assign sel_valid = valid_q[idx][way_sel];
	assign sel_dirty = dirty_q[idx][way_sel];
	assign sel_tag   = tag_q[idx][way_sel];

	// status bits
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int s = 0; s < dcache_pkg::SETS; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
				lru_q[s]   <= '0;
			end
		end else begin
			if (tag_we) begin
				valid_q[idx][way_sel] <= new_valid;
				dirty_q[idx][way_sel] <= new_dirty;
			end
			// the other way becomes the victim
			if (touch) begin
				lru_q[idx] <= ~hit_way;
			end
		end
	end

	// tag storage
	always_ff @(posedge CLK) begin
		if (tag_we) begin
			tag_q[idx][way_sel] <= new_tag;
		end
	end

	// no set holds the same tag in both valid ways
	for (genvar s = 0; s < dcache_pkg::SETS; s++) begin : g_uniq
		a_uniq_tag: assert property (@(posedge CLK) disable iff (!nRST)
			!(&valid_q[s] && (tag_q[s][0] == tag_q[s][1])));
	end

endmodule

/* design/dcache_data_array.sv */
`timescale 1ns/10ps

module dcache_data_array (
	input  logic                CLK,
	input  dcache_pkg::idx_t    idx,
	input  dcache_pkg::way_t    way,
	input  dcache_pkg::blkoff_t word,
	input  logic                we,
	input  dcache_pkg::word_t   wdata,
	output dcache_pkg::word_t   rdata
);

	// word storage by set x way x word
	dcache_pkg::word_t mem_q [dcache_pkg::SETS][dcache_pkg::WAYS][dcache_pkg::WORDS_PER_BLK];

	// single write port
	always_ff @(posedge CLK) begin
		if (we) begin
			mem_q[idx][way][word] <= wdata;
		end
	end

	// combinational read at the write address
	// store hit and refill see old data until the edge
	assign rdata = mem_q[idx][way][word];

endmodule

/* design/dcache_ctrl.sv */
`timescale 1ns/10ps

module dcache_ctrl (
	input  logic                CLK,
	input  logic                nRST,
	// datapath side
	input  logic                halt,
	input  logic                dmem_ren,
	input  logic                dmem_wen,
	input  dcache_pkg::word_t   dmem_addr,
	input  dcache_pkg::word_t   dmem_store,
	output logic                dhit,
	output dcache_pkg::word_t   dmem_load,
	output logic                flushed,
	// memory side
	output logic                mem_ren,
	output logic                mem_wen,
	output dcache_pkg::word_t   mem_addr,
	output dcache_pkg::word_t   mem_store,
	input  dcache_pkg::word_t   mem_load,
	input  logic                mem_wait,
	// tag array
	output dcache_pkg::idx_t    idx,
	output dcache_pkg::tag_t    tag,
	output dcache_pkg::way_t    way_sel,
	output logic                tag_we,
	output logic                new_valid,
	output logic                new_dirty,
	output dcache_pkg::tag_t    new_tag,
	output logic                touch,
	input  logic                hit,
	input  dcache_pkg::way_t    hit_way,
	input  dcache_pkg::way_t    lru_way,
	input  logic                sel_valid,
	input  logic                sel_dirty,
	input  dcache_pkg::tag_t    sel_tag,
	// data array
	output dcache_pkg::way_t    data_way,
	output dcache_pkg::blkoff_t data_word,
	output logic                data_we,
	output dcache_pkg::word_t   data_wdata,
	input  dcache_pkg::word_t   data_rdata
);

	typedef enum logic [2:0] {IDLE, WRITEBACK, REFILL, FLUSH, DONE} state_t;

	state_t                              state, nxt_state;
	dcache_pkg::way_t                    vic_way;
	dcache_pkg::blkoff_t                 word_cnt;
	logic [dcache_pkg::FLUSH_CNT_W-1:0]  flush_cnt;

	dcache_pkg::tag_t    req_tag;
	dcache_pkg::idx_t    req_idx;
	dcache_pkg::blkoff_t req_off;
	logic                req, miss, word_last;
	dcache_pkg::idx_t    f_idx;
	dcache_pkg::way_t    f_way;
	dcache_pkg::blkoff_t f_word;
	logic                f_need, f_step;

	// request fields held stable by the datapath through a miss
	assign req_tag = dmem_addr[dcache_pkg::TAG_LSB +: dcache_pkg::TAG_W];
	assign req_idx = dmem_addr[dcache_pkg::IDX_LSB +: dcache_pkg::IDX_W];
	assign req_off = dmem_addr[dcache_pkg::BYTEOFF_W +: dcache_pkg::BLKOFF_W];
	assign req     = dmem_ren || dmem_wen;
	assign miss    = (state == IDLE) && !halt && req && !hit;

	assign word_last = (word_cnt == dcache_pkg::blkoff_t'(dcache_pkg::WORDS_PER_BLK - 1));

	// flush walk order set | way | word
	assign f_word = flush_cnt[0 +: dcache_pkg::BLKOFF_W];
	assign f_way  = flush_cnt[dcache_pkg::BLKOFF_W +: dcache_pkg::WAY_W];
	assign f_idx  = flush_cnt[dcache_pkg::FLUSH_CNT_W-1 -: dcache_pkg::IDX_W];
	// only dirty valid words go to memory
	assign f_need = sel_valid && sel_dirty;
	assign f_step = !f_need || !mem_wait;

	assign tag       = req_tag;
	assign dmem_load = data_rdata;
	assign mem_store = data_rdata;
	// stays high until reset
	assign flushed   = (state == DONE);

	always_comb begin
		nxt_state  = state;
		dhit       = 1'b0;
		mem_ren    = 1'b0;
		mem_wen    = 1'b0;
		mem_addr   = {req_tag, req_idx, word_cnt, {dcache_pkg::BYTEOFF_W{1'b0}}};
		idx        = req_idx;
		way_sel    = vic_way;
		tag_we     = 1'b0;
		new_valid  = 1'b1;
		new_dirty  = 1'b0;
		new_tag    = req_tag;
		touch      = 1'b0;
		data_way   = vic_way;
		data_word  = word_cnt;
		data_we    = 1'b0;
		data_wdata = mem_load;
		case (state)
			IDLE: begin
				// hit way for access, lru way for victim check
				way_sel    = hit ? hit_way : lru_way;
				data_way   = hit_way;
				data_word  = req_off;
				data_wdata = dmem_store;
				if (halt) begin
					nxt_state = FLUSH;
				end else if (req && hit) begin
					dhit  = 1'b1;
					touch = 1'b1;
					// store marks the block dirty
					if (dmem_wen) begin
						data_we   = 1'b1;
						tag_we    = 1'b1;
						new_dirty = 1'b1;
					end
				end else if (req) begin
					nxt_state = (sel_valid && sel_dirty) ? WRITEBACK : REFILL;
				end
			end
			WRITEBACK: begin
				// victim address from its own tag
				mem_wen  = 1'b1;
				mem_addr = {sel_tag, req_idx, word_cnt, {dcache_pkg::BYTEOFF_W{1'b0}}};
				if (!mem_wait && word_last) begin
					nxt_state = REFILL;
				end
			end
			REFILL: begin
				mem_ren = 1'b1;
				data_we = !mem_wait;
				// install tag clean with the last word
				if (!mem_wait && word_last) begin
					tag_we    = 1'b1;
					nxt_state = IDLE;
				end
			end
			FLUSH: begin
				idx       = f_idx;
				way_sel   = f_way;
				data_way  = f_way;
				data_word = f_word;
				mem_wen   = f_need;
				mem_addr  = {sel_tag, f_idx, f_word, {dcache_pkg::BYTEOFF_W{1'b0}}};
				new_valid = 1'b0;
				new_tag   = sel_tag;
				// invalidate after the last word of the block
				if (f_step && (f_word == dcache_pkg::blkoff_t'(dcache_pkg::WORDS_PER_BLK - 1))) begin
					tag_we = 1'b1;
				end
				if (f_step && (&flush_cnt)) begin
					nxt_state = DONE;
				end
			end
			default: begin
				nxt_state = DONE;
			end
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state     <= IDLE;
			vic_way   <= '0;
			word_cnt  <= '0;
			flush_cnt <= '0;
		end else begin
			state <= nxt_state;
			if (miss) begin
				vic_way <= lru_way;
			end
			// wraps to zero at the end of each block
			if ((state == WRITEBACK || state == REFILL) && !mem_wait) begin
				word_cnt <= word_cnt + 1'b1;
			end
			if (state == FLUSH && f_step) begin
				flush_cnt <= flush_cnt + 1'b1;
			end
		end
	end

	a_mem_excl: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_ren && mem_wen));

	// request held under back-pressure
	a_mem_hold: assert property (@(posedge CLK) disable iff (!nRST)
		(mem_ren || mem_wen) && mem_wait |=>
		$stable(mem_ren) && $stable(mem_wen) && $stable(mem_addr));

endmodule

/* design/dcache_top.sv */
`timescale 1ns/10ps

module dcache_top (
	input  logic              CLK,
	input  logic              nRST,
	// datapath side
	input  logic              halt,
	input  logic              dmem_ren,
	input  logic              dmem_wen,
	input  dcache_pkg::word_t dmem_addr,
	input  dcache_pkg::word_t dmem_store,
	output logic              dhit,
	output dcache_pkg::word_t dmem_load,
	output logic              flushed,
	// memory side
	output logic              mem_ren,
	output logic              mem_wen,
	output dcache_pkg::word_t mem_addr,
	output dcache_pkg::word_t mem_store,
	input  dcache_pkg::word_t mem_load,
	input  logic              mem_wait
);

	// tag array wires
	dcache_pkg::idx_t    idx;
	dcache_pkg::tag_t    tag, new_tag, sel_tag;
	dcache_pkg::way_t    way_sel, hit_way, lru_way;
	logic                tag_we, new_valid, new_dirty, touch;
	logic                hit, sel_valid, sel_dirty;
	// data array wires
	dcache_pkg::way_t    data_way;
	dcache_pkg::blkoff_t data_word;
	logic                data_we;
	dcache_pkg::word_t   data_wdata, data_rdata;

	dcache_ctrl i_ctrl (.*);

	dcache_tag_array i_tags (.*);

	// data array shares the controller index
	dcache_data_array i_data (
		.CLK   (CLK),
		.idx   (idx),
		.way   (data_way),
		.word  (data_word),
		.we    (data_we),
		.wdata (data_wdata),
		.rdata (data_rdata)
	);

endmodule

/* tb/tb_dcache.sv */
`timescale 1ns/10ps

module tb_dcache;

	localparam int MEM_WORDS   = 1024;
	localparam int HIT_LIMIT   = 300;
	localparam int FLUSH_LIMIT = 1000;
	localparam int RAND_OPS    = 200;

	logic              CLK, nRST, halt, dmem_ren, dmem_wen, dhit, flushed;
	logic              mem_ren, mem_wen, mem_wait;
	dcache_pkg::word_t dmem_addr, dmem_store, dmem_load, mem_addr, mem_store, mem_load;

	// main memory model and the memory image the datapath expects
	dcache_pkg::word_t mem [MEM_WORDS];
	dcache_pkg::word_t shadow [MEM_WORDS];

	logic [31:0] stim_lfsr, wait_lfsr;
	logic [1:0]  wait_left;
	string       test_name;
	int          err_cnt, timeout_cnt, check_cnt;
	logic        hung, mem_checked;

	dcache_top i_dut (.*);

	initial begin
		CLK = 1'b0;
		forever begin
			#10 CLK = ~CLK;
		end
	end

	// galois lfsr with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] take_bits(inout logic [31:0] s, input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			s = lfsr_next(s);
			r = {r[30:0], s[0]};
		end
		return r;
	endfunction

	// odd multiplier gives every word address its own value
	function automatic dcache_pkg::word_t fill_word(input int i);
		return 32'h5A5A0000 ^ (32'(i) * 32'h9E3779B1);
	endfunction

	// last completed store to the word, or its preload
	function automatic dcache_pkg::word_t ref_load(input dcache_pkg::word_t addr);
		return shadow[addr[11:2]];
	endfunction

	// memory side with 0 to 3 wait cycles per word
	always @(negedge CLK) begin
		if (nRST && (mem_ren || mem_wen) && (wait_left == 2'd0)) begin
			mem_wait = 1'b0;
			mem_load = mem[mem_addr[11:2]];
			// word moves at the next rising edge while the request is held
			if (mem_wen) begin
				mem[mem_addr[11:2]] = mem_store;
			end
			wait_left = 2'(take_bits(wait_lfsr, 2));
		end else if (nRST && (mem_ren || mem_wen)) begin
			mem_wait  = 1'b1;
			wait_left = wait_left - 2'd1;
		end else begin
			mem_wait = 1'b1;
		end
	end

	// completed loads against the reference and stores into the shadow
	always @(posedge CLK) begin
		if (nRST && dhit && dmem_ren) begin
			check_cnt++;
			assert (dmem_load == ref_load(dmem_addr)) else begin
				$display("Error %s: expected %h, actual %h", test_name,
					ref_load(dmem_addr), dmem_load);
				err_cnt++;
			end
		end else if (nRST && dhit && dmem_wen) begin
			shadow[dmem_addr[11:2]] = dmem_store;
		end
		// whole memory once the flush is over
		if (nRST && flushed && !mem_checked) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				check_cnt++;
				assert (mem[i] == shadow[i]) else begin
					$display("Error %s word %0d: expected %h, actual %h", test_name, i,
						shadow[i], mem[i]);
					err_cnt++;
				end
			end
			mem_checked = 1'b1;
		end
	end

	// starts on a falling edge and returns on the falling edge after dhit
	task automatic access(input logic wr, input dcache_pkg::word_t addr,
			input dcache_pkg::word_t data);
		int cycles;
		if (hung) begin
			return;
		end
		dmem_ren   = !wr;
		dmem_wen   = wr;
		dmem_addr  = addr;
		dmem_store = data;
		cycles     = 0;
		@(posedge CLK);
		while (!dhit && cycles < HIT_LIMIT) begin
			cycles++;
			@(posedge CLK);
		end
		if (!dhit) begin
			$display("Timeout in %s: no dhit for address %h", test_name, addr);
			timeout_cnt++;
			hung = 1'b1;
		end
		@(negedge CLK);
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
	endtask

	task automatic wait_flushed();
		int cycles;
		cycles = 0;
		while (!flushed && cycles < FLUSH_LIMIT) begin
			@(posedge CLK);
			cycles++;
		end
		if (!flushed) begin
			$display("Timeout: flushed never rose after halt");
			timeout_cnt++;
		end
	endtask

	initial begin
		logic              wr;
		dcache_pkg::word_t addr;
		nRST       = 1'b0;
		halt       = 1'b0;
		dmem_ren   = 1'b0;
		dmem_wen   = 1'b0;
		dmem_addr  = '0;
		dmem_store = '0;
		mem_load   = '0;
		mem_wait   = 1'b1;
		stim_lfsr  = 32'd80891;
		wait_lfsr  = 32'd80891;
		wait_left  = '0;
		err_cnt    = 0;
		timeout_cnt = 0;
		check_cnt  = 0;
		hung       = 1'b0;
		mem_checked = 1'b0;
		test_name  = "reset";
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i]    = fill_word(i);
			shadow[i] = fill_word(i);
		end
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		assert (!dhit && !mem_ren && !mem_wen && !flushed) else begin
			$display("an output was high after reset");
			err_cnt++;
		end
		nRST = 1'b1;

		// cold miss then the other word of the refilled block
		test_name = "read miss";
		access(1'b0, 32'h0000_0100, '0);
		test_name = "same block";
		access(1'b0, 32'h0000_0104, '0);

		test_name = "store load";
		access(1'b1, 32'h0000_0300, 32'h1357_2468);
		access(1'b0, 32'h0000_0300, '0);

		// set 5 with tags 8 9 10 where the third store evicts the first
		test_name = "eviction";
		access(1'b1, 32'h0000_0228, 32'h0BAD_F00D);
		access(1'b1, 32'h0000_0268, 32'h2222_3333);
		access(1'b1, 32'h0000_02A8, 32'h4444_5555);
		check_cnt++;
		assert (mem[32'h228 >> 2] == 32'h0BAD_F00D) else begin
			$display("Error %s: expected %h, actual %h", test_name, 32'h0BAD_F00D,
				mem[32'h228 >> 2]);
			err_cnt++;
		end
		access(1'b0, 32'h0000_0228, '0);

		// 64 word window gives four tags per set
		test_name = "random";
		for (int n = 0; n < RAND_OPS; n++) begin
			wr   = (take_bits(stim_lfsr, 1) != '0);
			addr = take_bits(stim_lfsr, 6) << 2;
			access(wr, addr, take_bits(stim_lfsr, 32));
		end

		test_name = "flush";
		halt = 1'b1;
		wait_flushed();
		// flushed holds until reset
		repeat (4) begin
			@(posedge CLK);
			assert (flushed) else begin
				$display("flushed went low after the flush");
				err_cnt++;
			end
		end
		assert (mem_checked) else begin
			$display("final memory compare never ran");
			err_cnt++;
		end

		$display("checks: %0d, errors: %0d, timeouts: %0d", check_cnt, err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* project.f */
design/dcache_pkg.sv
design/dcache_tag_array.sv
design/dcache_data_array.sv
design/dcache_ctrl.sv
design/dcache_top.sv
tb/tb_dcache.sv

/* run.sh */
#!/bin/bash
# build and run the dcache testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_dcache -Mdir obj_dir -o sim_dcache

./obj_dir/sim_dcache | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation reported failure, see sim.log"
	exit 1
fi
echo "simulation log in sim.log"
